/* hw/analyzer_pkg.sv */
`default_nettype none

package analyzer_pkg;

	localparam int NUM_ROUTES  = 6;
	localparam int SAMPLE_W    = 31;
	localparam int RECORD_W    = 32;
	localparam int CREDIT_INIT = 4; // Matches the receiver buffer size
	localparam int CREDIT_W    = $clog2(CREDIT_INIT + 1);
	localparam int FIFO_DEPTH  = 8;
	localparam int FIFO_ADR_W  = $clog2(FIFO_DEPTH);
	localparam int REG_ADR_W   = 4;

	// Host register map
	localparam logic [REG_ADR_W-1:0] REG_ATOM0            = 4'd0;
	localparam logic [REG_ADR_W-1:0] REG_ATOM1            = 4'd1;
	localparam logic [REG_ADR_W-1:0] REG_ATOM2            = 4'd2;
	localparam logic [REG_ADR_W-1:0] REG_ATOM3            = 4'd3;
	localparam logic [REG_ADR_W-1:0] REG_ONES_SET         = 4'd4;
	localparam logic [REG_ADR_W-1:0] REG_REC_CTRL         = 4'd5;
	localparam logic [REG_ADR_W-1:0] REG_PA_SET           = 4'd6;
	localparam logic [REG_ADR_W-1:0] REG_PA_CLEAR         = 4'd7;
	localparam logic [REG_ADR_W-1:0] REG_PA_TRIG_SET      = 4'd8;
	localparam logic [REG_ADR_W-1:0] REG_PA_TRIG_CLEAR    = 4'd9;
	localparam logic [REG_ADR_W-1:0] REG_CMP_VALUE        = 4'd10;
	localparam logic [REG_ADR_W-1:0] REG_CMP_MASK         = 4'd11;
	localparam logic [REG_ADR_W-1:0] REG_CMP_LEVEL_ROUTES = 4'd12;
	localparam logic [REG_ADR_W-1:0] REG_CMP_EDGE_ROUTES  = 4'd13;

	// Bit positions in a recording control write
	localparam int REC_START_SEL = 0;
	localparam int REC_STOP_SEL  = 1;
	localparam int REC_CAP_SEL   = 2;
	localparam int REC_START_NOW = 3;
	localparam int REC_STOP_NOW  = 4;
	localparam int REC_CAP_NOW   = 5;

	typedef logic [NUM_ROUTES-1:0] route_t;

	typedef struct packed {
		logic [14:0] adr;
		logic [7:0]  data;
		logic        rd;
		logic        wr;
		logic        cs_rom;
		logic        cs_xram;
		logic        phi;
		logic        reset;
	} bus_pins_t;

	typedef struct packed {
		logic        pa0;
		logic        reset;
		logic        phi;
		logic        wr;
		logic        rd;
		logic        cs_xram;
		logic        data_dir; // Nothing drives the data bus in this design so it stays zero
		logic [7:0]  data;
		logic        cs_rom;
		logic [14:0] adr;
	} sample_fields_t;

	typedef union packed {
		logic [SAMPLE_W-1:0] raw;
		sample_fields_t      f;
	} sample_u;

	typedef struct packed {
		logic    stop;
		sample_u sample;
	} record_t;

	typedef struct packed {
		logic                 wr;
		logic [REG_ADR_W-1:0] adr;
		logic [7:0]           data;
	} reg_wr_t;

	typedef struct packed {
		route_t     ones_set;
		route_t     pa_trig_set;
		route_t     pa_trig_clear;
		route_t     cmp_level;
		route_t     cmp_edge;
		route_t     rec_start;
		route_t     rec_stop;
		route_t     rec_capture;
		sample_u    cmp_value;
		sample_u    cmp_mask;
		logic [7:0] pa_set_mask;   // One cycle pulse
		logic [7:0] pa_clear_mask; // One cycle pulse
		logic       start_now;
		logic       stop_now;
		logic       cap_now;
	} analyzer_cfg_t;

endpackage

`default_nettype wire

/* hw/bus_comparator.sv */
`default_nettype none

module bus_comparator
	import analyzer_pkg::*;
(
	input  logic    pllclk,
	input  logic    f_reset,
	input  sample_u sample,
	input  sample_u cmp_value,
	input  sample_u cmp_mask,
	input  route_t  level_routes,
	input  route_t  edge_routes,
	input  route_t  ones_set,
	output route_t  route
);

	logic   match;
	logic   prev_match;
	route_t route_next;

	// Only bits set in the mask take part in the compare
	assign match = ((sample.raw ^ cmp_value.raw) & cmp_mask.raw) == '0;

	always_comb begin
		route_next = ones_set;

		if (match) begin
			route_next |= level_routes;
			if (!prev_match)
				route_next |= edge_routes; // First matching cycle only
		end
	end

	always_ff @(posedge pllclk) begin
		prev_match <= match;
		route      <= route_next;

		if (f_reset) begin
			prev_match <= 1'b0;
			route      <= '0;
		end
	end

endmodule

`default_nettype wire

/* hw/bus_sampler.sv */
`default_nettype none

module bus_sampler
	import analyzer_pkg::*;
(
	input  logic      pllclk,
	input  bus_pins_t pins,
	input  logic      pa0,
	output sample_u   sample
);

	bus_pins_t pins_meta, pins_sync;
	logic      pa0_meta, pa0_sync;

	// DUT pins are asynchronous to pllclk
	always_ff @(posedge pllclk) begin
		pins_meta <= pins;
		pins_sync <= pins_meta;
		pa0_meta  <= pa0;
		pa0_sync  <= pa0_meta;
	end

	always_comb begin
		sample.f.pa0      = pa0_sync;
		sample.f.reset    = pins_sync.reset;
		sample.f.phi      = pins_sync.phi;
		sample.f.wr       = pins_sync.wr;
		sample.f.rd       = pins_sync.rd;
		sample.f.cs_xram  = pins_sync.cs_xram;
		sample.f.data_dir = 1'b0;
		sample.f.data     = pins_sync.data;
		sample.f.cs_rom   = pins_sync.cs_rom;
		sample.f.adr      = pins_sync.adr;
	end

endmodule

`default_nettype wire

/* hw/capture_recorder.sv */
`default_nettype none

module capture_recorder
	import analyzer_pkg::*;
(
	input  logic    pllclk,
	input  logic    f_reset,
	input  sample_u sample,
	input  route_t  route,
	input  route_t  sel_start,
	input  route_t  sel_stop,
	input  route_t  sel_capture,
	input  logic    start_now,
	input  logic    stop_now,
	input  logic    cap_now,
	output logic    push,
	output record_t record
);

	logic running;
	logic start, stop, capture;

	always_comb begin
		start = |(sel_start & route) || start_now;
		stop  = |(sel_stop & route) || stop_now;

		// Start and stop together act as a toggle
		if (running)
			start = 1'b0;
		else
			stop = 1'b0;

		capture = stop || (running && (|(sel_capture & route) || cap_now));
	end

	always_ff @(posedge pllclk) begin
		push <= capture;

		if (start || stop)
			running <= start;

		if (f_reset) begin
			push    <= 1'b0;
			running <= 1'b0;
		end
	end

	always_ff @(posedge pllclk) begin
		if (capture) begin
			record.stop   <= stop; // Last record of a run carries the flag
			record.sample <= sample;
		end
	end

endmodule

`default_nettype wire

/* hw/config_regs.sv */
`default_nettype none

module config_regs
	import analyzer_pkg::*;
(
	input  logic          pllclk,
	input  logic          f_reset,
	input  reg_wr_t       reg_wr,
	output analyzer_cfg_t cfg
);

	logic [RECORD_W-1:0] atom; // Wide values load from this staging word in one go

	always_ff @(posedge pllclk) begin
		if (reg_wr.wr) begin
			case (reg_wr.adr)
			REG_ATOM0:
				atom[7:0] <= reg_wr.data;
			REG_ATOM1:
				atom[15:8] <= reg_wr.data;
			REG_ATOM2:
				atom[23:16] <= reg_wr.data;
			REG_ATOM3:
				atom[31:24] <= reg_wr.data;
			default: ;
			endcase
		end
	end

	always_ff @(posedge pllclk) begin
		cfg.pa_set_mask   <= '0;
		cfg.pa_clear_mask <= '0;
		cfg.start_now     <= 1'b0;
		cfg.stop_now      <= 1'b0;
		cfg.cap_now       <= 1'b0;

		if (reg_wr.wr) begin
			case (reg_wr.adr)
			REG_ONES_SET:
				cfg.ones_set <= atom[NUM_ROUTES-1:0];
			REG_REC_CTRL: begin
				// Each select bit picks which route set gets the atom
				if (reg_wr.data[REC_START_SEL])
					cfg.rec_start <= atom[NUM_ROUTES-1:0];
				if (reg_wr.data[REC_STOP_SEL])
					cfg.rec_stop <= atom[NUM_ROUTES-1:0];
				if (reg_wr.data[REC_CAP_SEL])
					cfg.rec_capture <= atom[NUM_ROUTES-1:0];
				cfg.start_now <= reg_wr.data[REC_START_NOW];
				cfg.stop_now  <= reg_wr.data[REC_STOP_NOW];
				cfg.cap_now   <= reg_wr.data[REC_CAP_NOW];
			end
			REG_PA_SET:
				cfg.pa_set_mask <= reg_wr.data;
			REG_PA_CLEAR:
				cfg.pa_clear_mask <= reg_wr.data;
			REG_PA_TRIG_SET:
				cfg.pa_trig_set <= atom[NUM_ROUTES-1:0];
			REG_PA_TRIG_CLEAR:
				cfg.pa_trig_clear <= atom[NUM_ROUTES-1:0];
			REG_CMP_VALUE:
				cfg.cmp_value.raw <= atom[SAMPLE_W-1:0];
			REG_CMP_MASK:
				cfg.cmp_mask.raw <= atom[SAMPLE_W-1:0];
			REG_CMP_LEVEL_ROUTES:
				cfg.cmp_level <= atom[NUM_ROUTES-1:0];
			REG_CMP_EDGE_ROUTES:
				cfg.cmp_edge <= atom[NUM_ROUTES-1:0];
			default: ;
			endcase
		end

		if (f_reset)
			cfg <= '0;
	end

endmodule

`default_nettype wire

/* hw/logic_analyzer_top.sv */
`default_nettype none

module logic_analyzer_top
	import analyzer_pkg::*;
(
	input  logic       pllclk,
	input  logic       f_reset,
	input  reg_wr_t    reg_wr,
	input  bus_pins_t  pins,
	input  logic [7:0] pa_in,
	output logic [7:0] pa_out,
	output logic       rec_valid,
	output record_t    rec_data,
	input  logic       credit_return,
	output logic       overflow
);

	analyzer_cfg_t cfg;
	sample_u       sample;
	route_t        route;
	logic          push;
	record_t       record;

	config_regs u_config_regs (
		.pllclk  (pllclk),
		.f_reset (f_reset),
		.reg_wr  (reg_wr),
		.cfg     (cfg)
	);

	bus_sampler u_bus_sampler (
		.pllclk (pllclk),
		.pins   (pins),
		.pa0    (pa_in[0]), // Only bit 0 of port A is sampled
		.sample (sample)
	);

	bus_comparator u_bus_comparator (
		.pllclk       (pllclk),
		.f_reset      (f_reset),
		.sample       (sample),
		.cmp_value    (cfg.cmp_value),
		.cmp_mask     (cfg.cmp_mask),
		.level_routes (cfg.cmp_level),
		.edge_routes  (cfg.cmp_edge),
		.ones_set     (cfg.ones_set),
		.route        (route)
	);

	port_a_driver u_port_a_driver (
		.pllclk     (pllclk),
		.f_reset    (f_reset),
		.route      (route),
		.set_mask   (cfg.pa_set_mask),
		.clear_mask (cfg.pa_clear_mask),
		.trig_set   (cfg.pa_trig_set),
		.trig_clear (cfg.pa_trig_clear),
		.pa_out     (pa_out)
	);

	capture_recorder u_capture_recorder (
		.pllclk      (pllclk),
		.f_reset     (f_reset),
		.sample      (sample),
		.route       (route),
		.sel_start   (cfg.rec_start),
		.sel_stop    (cfg.rec_stop),
		.sel_capture (cfg.rec_capture),
		.start_now   (cfg.start_now),
		.stop_now    (cfg.stop_now),
		.cap_now     (cfg.cap_now),
		.push        (push),
		.record      (record)
	);

	record_fifo u_record_fifo (
		.pllclk        (pllclk),
		.f_reset       (f_reset),
		.push          (push),
		.record        (record),
		.credit_return (credit_return),
		.rec_valid     (rec_valid),
		.rec_data      (rec_data),
		.overflow      (overflow)
	);

endmodule

`default_nettype wire

/* hw/port_a_driver.sv */
`default_nettype none

module port_a_driver
	import analyzer_pkg::*;
(
	input  logic       pllclk,
	input  logic       f_reset,
	input  route_t     route,
	input  logic [7:0] set_mask,
	input  logic [7:0] clear_mask,
	input  route_t     trig_set,
	input  route_t     trig_clear,
	output logic [7:0] pa_out
);

	logic [7:0] set_bits, clear_bits;

	// Routed triggers reach bit 0 only
	assign set_bits   = set_mask | {7'b0, |(trig_set & route)};
	assign clear_bits = clear_mask | {7'b0, |(trig_clear & route)};

	always_ff @(posedge pllclk) begin
		pa_out <= (pa_out | set_bits) & ~clear_bits;

		if (f_reset)
			pa_out <= '0;
	end

endmodule

`default_nettype wire

/* hw/record_fifo.sv */
`default_nettype none

module record_fifo
	import analyzer_pkg::*;
(
	input  logic    pllclk,
	input  logic    f_reset,
	input  logic    push,
	input  record_t record,
	input  logic    credit_return,
	output logic    rec_valid,
	output record_t rec_data,
	output logic    overflow
);

	record_t             mem [FIFO_DEPTH];
	logic [FIFO_ADR_W:0] wr_ptr, rd_ptr; // Top bit tells full from empty
	logic [CREDIT_W-1:0] credits;
	logic                empty, full;
	logic                write, pop;

	assign empty = wr_ptr == rd_ptr;
	assign full  = wr_ptr == {~rd_ptr[FIFO_ADR_W], rd_ptr[FIFO_ADR_W-1:0]};
	assign write = push && !full;
	assign pop   = !empty && credits != '0;

	// The head word is offered straight from the buffer
	assign rec_valid = pop;
	assign rec_data  = mem[rd_ptr[FIFO_ADR_W-1:0]];

	always_ff @(posedge pllclk) begin
		if (write)
			mem[wr_ptr[FIFO_ADR_W-1:0]] <= record;
	end

	always_ff @(posedge pllclk) begin
		if (write)
			wr_ptr <= wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;

		credits <= credits - CREDIT_W'(pop) + CREDIT_W'(credit_return);

		if (push && full)
			overflow <= 1'b1; // The record is lost and the flag holds until reset

		if (f_reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			credits  <= CREDIT_W'(CREDIT_INIT);
			overflow <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic_analyzer.f */
+incdir+include
hw/analyzer_pkg.sv
hw/config_regs.sv
hw/bus_sampler.sv
hw/bus_comparator.sv
hw/port_a_driver.sv
hw/capture_recorder.sv
hw/record_fifo.sv
hw/logic_analyzer_top.sv
tests/tb_logic_analyzer.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_logic_analyzer -f logic_analyzer.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF "*** PASSED ***"; then
	exit 0
fi
exit 1

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_TESTS = 6;
localparam int MAX_WR    = 12;
localparam logic [14:0] MATCH_ADR = 15'h0150; // Comparator value written below

typedef struct packed {
	int pa_in;
	int n_steps;     // Random pin patterns after the writes
	int hold;        // Cycles each pattern is held
	int match_steps; // Bit per step that is set when that pattern matches
	int level_cap;   // Records come from level matches
	int n_credits;
	int lat_wr;      // Write whose record latency is measured or -1 for none
	int exp_lat;
	int exp_pa;
	int exp_count;
	int stop_mask;   // Bit per record that is set when its stop flag is expected
	int exp_ovf;
	int budget;
} test_row_t;

test_row_t rows [NUM_TESTS];
string     names [NUM_TESTS];
reg_wr_t   wr_tab [NUM_TESTS][MAX_WR];
int        n_wr [NUM_TESTS];

function automatic void define_row(int t, string name, int pa, int steps, int hold,
		int match, int level, int credits, int lat_wr, int lat, int exp_pa,
		int count, int stop_mask, int ovf, int budget);
	names[t] = name;
	rows[t]  = {pa, steps, hold, match, level, credits, lat_wr, lat, exp_pa,
		count, stop_mask, ovf, budget};
endfunction

function automatic void add_wr(int t, logic [REG_ADR_W-1:0] adr, logic [7:0] data);
	wr_tab[t][n_wr[t]] = {1'b1, adr, data};
	n_wr[t]++;
endfunction

// Value 0x0150 on the address with a mask over the whole address
function automatic void add_cmp_setup(int t);
	add_wr(t, REG_ATOM0, 8'h50);
	add_wr(t, REG_ATOM1, 8'h01);
	add_wr(t, REG_ATOM2, 8'h00);
	add_wr(t, REG_ATOM3, 8'h00);
	add_wr(t, REG_CMP_VALUE, 8'h00);
	add_wr(t, REG_ATOM0, 8'hFF);
	add_wr(t, REG_ATOM1, 8'h7F);
	add_wr(t, REG_CMP_MASK, 8'h00);
endfunction

function automatic void build_table();
	for (int t = 0; t < NUM_TESTS; t++)
		n_wr[t] = 0;

	//          t  name                  pa   st hd match    lv cr lw la pa   n  stop ov bud
	define_row(0, "after_reset",        'h00, 0, 1, 0,       0, 0, -1, 0, 'h00, 0, 0, 0, 80);
	define_row(1, "port_a_masks",       'h00, 0, 1, 0,       0, 0, -1, 0, 'h52, 0, 0, 0, 80);
	define_row(2, "immediate_commands", 'hA5, 0, 1, 0,       0, 0, 1, 3, 'h00, 2, 2, 0, 80);
	define_row(3, "level_capture",      'h00, 8, 2, 'h2C,    1, 2, -1, 0, 'h00, 6, 0, 0, 80);
	define_row(4, "edge_to_port_a",     'h00, 3, 2, 'h2,     0, 0, -1, 0, 'h01, 0, 0, 0, 80);
	define_row(5, "credits_overflow",   'h01, 16, 1, 'h7FFE, 1, 3, -1, 0, 'h00, 7, 0, 1, 80);

	add_wr(1, REG_PA_SET, 8'h5A);
	add_wr(1, REG_PA_CLEAR, 8'h0C);

	add_wr(2, REG_REC_CTRL, 8'h08); // Start now
	add_wr(2, REG_REC_CTRL, 8'h20); // Capture now
	add_wr(2, REG_REC_CTRL, 8'h10); // Stop now

	add_cmp_setup(3);
	add_wr(3, REG_ATOM0, 8'h01);
	add_wr(3, REG_CMP_LEVEL_ROUTES, 8'h00);
	add_wr(3, REG_REC_CTRL, 8'h0C); // Capture select from atom and start now

	add_cmp_setup(4);
	add_wr(4, REG_ATOM0, 8'h02);
	add_wr(4, REG_CMP_EDGE_ROUTES, 8'h00);
	add_wr(4, REG_PA_TRIG_SET, 8'h00);

	add_cmp_setup(5);
	add_wr(5, REG_ATOM0, 8'h01);
	add_wr(5, REG_CMP_LEVEL_ROUTES, 8'h00);
	add_wr(5, REG_REC_CTRL, 8'h0C);
endfunction

`endif

/* tests/tb_logic_analyzer.sv */
`default_nettype none

module tb_logic_analyzer
	import analyzer_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	`include "tb_vectors.svh"

	logic       pllclk;
	logic       f_reset;
	reg_wr_t    reg_wr;
	bus_pins_t  pins;
	logic [7:0] pa_in;
	logic [7:0] pa_out;
	logic       rec_valid;
	record_t    rec_data;
	logic       credit_return;
	logic       overflow;

	logic [31:0] lfsr;
	int          cycle;
	int          errors;
	int          failed_tests;
	logic        table_ready;
	record_t     got [$];
	int          got_cyc [$];

	logic_analyzer_top u_logic_analyzer_top (
		.pllclk        (pllclk),
		.f_reset       (f_reset),
		.reg_wr        (reg_wr),
		.pins          (pins),
		.pa_in         (pa_in),
		.pa_out        (pa_out),
		.rec_valid     (rec_valid),
		.rec_data      (rec_data),
		.credit_return (credit_return),
		.overflow      (overflow)
	);

	always #5 pllclk = ~pllclk;

	always @(posedge pllclk) begin
		cycle <= cycle + 1;
		if (!f_reset && rec_valid) begin
			got.push_back(rec_data);
			got_cyc.push_back(cycle - 1); // Cycle in which rec_valid was high
		end
	end

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr[0])
				lfsr = (lfsr >> 1) ^ 32'h80200003;
			else
				lfsr = lfsr >> 1;
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic bus_pins_t make_pins(logic matching);
		bus_pins_t   p;
		logic [31:0] bits;
		bits      = rand_bits(15);
		p.adr     = bits[14:0];
		bits      = rand_bits(8);
		p.data    = bits[7:0];
		p.rd      = 1'b1;
		p.wr      = 1'b0;
		p.cs_rom  = 1'b1;
		p.cs_xram = 1'b0;
		p.phi     = 1'b1;
		p.reset   = 1'b0;
		if (matching)
			p.adr = MATCH_ADR;
		else if (p.adr == MATCH_ADR)
			p.adr = p.adr ^ 15'd1;
		return p;
	endfunction

	function automatic sample_u to_sample(bus_pins_t p, logic pa0);
		sample_u s;
		s.f.pa0      = pa0;
		s.f.reset    = p.reset;
		s.f.phi      = p.phi;
		s.f.wr       = p.wr;
		s.f.rd       = p.rd;
		s.f.cs_xram  = p.cs_xram;
		s.f.data_dir = 1'b0;
		s.f.data     = p.data;
		s.f.cs_rom   = p.cs_rom;
		s.f.adr      = p.adr;
		return s;
	endfunction

	task automatic apply_reset();
		@(posedge pllclk);
		f_reset       <= 1'b1;
		reg_wr        <= '0;
		credit_return <= 1'b0;
		repeat (10) @(posedge pllclk);
		f_reset <= 1'b0;
		@(posedge pllclk);
	endtask

	task automatic run_test(int t);
		test_row_t  row;
		bus_pins_t  pre;
		bus_pins_t  p;
		bus_pins_t  seq [$];
		record_t    exp [$];
		record_t    r;
		int         wr_cyc;
		int         n;
		int         errs;

		row  = rows[t];
		errs = 0;
		seq.delete();
		exp.delete();
		wr_cyc = 0;

		apply_reset();
		assert (pa_out == 8'h00 && rec_valid == 1'b0 && overflow == 1'b0) else begin
			$display("** Error: after reset pa_out = %h, rec_valid = %h, overflow = %h",
				pa_out, rec_valid, overflow);
			errs++;
		end
		got.delete();
		got_cyc.delete();

		pre = make_pins(1'b0);
		pins  <= pre;
		pa_in <= row.pa_in[7:0];
		repeat (4) @(posedge pllclk);

		for (int i = 0; i < n_wr[t]; i++) begin
			@(posedge pllclk);
			reg_wr <= wr_tab[t][i];
			if (i == row.lat_wr)
				wr_cyc = cycle;
		end
		@(posedge pllclk);
		reg_wr <= '0;
		repeat (3) @(posedge pllclk);

		for (int s = 0; s < row.n_steps; s++) begin
			p = make_pins(row.match_steps[s]);
			for (int h = 0; h < row.hold; h++) begin
				@(posedge pllclk);
				pins <= p;
				seq.push_back(p);
			end
		end
		p = make_pins(1'b0);
		repeat (4) begin
			@(posedge pllclk);
			pins <= p;
			seq.push_back(p);
		end
		repeat (6) @(posedge pllclk); // Let the pin pipeline drain

		// Without returned credits the sender may not exceed its initial credits
		assert (got.size() <= CREDIT_INIT) else begin
			$display("** Error: records before credit return = %h, at most %h",
				got.size(), CREDIT_INIT);
			errs++;
		end

		for (int c = 0; c < row.n_credits; c++) begin
			@(posedge pllclk);
			credit_return <= 1'b1;
		end
		@(posedge pllclk);
		credit_return <= 1'b0;

		// A level match records the sample present when its route arrives
		if (row.level_cap != 0) begin
			for (int i = 0; i + 1 < seq.size(); i++)
				if (seq[i].adr == MATCH_ADR)
					exp.push_back({1'b0, to_sample(seq[i + 1], row.pa_in[0])});
		end else begin
			for (int i = 0; i < row.exp_count; i++)
				exp.push_back({row.stop_mask[i], to_sample(pre, row.pa_in[0])});
		end

		n = 0;
		while (got.size() < row.exp_count && n < row.budget) begin
			@(posedge pllclk);
			n++;
		end
		repeat (8) @(posedge pllclk);

		assert (got.size() == row.exp_count) else begin
			$display("** Error: record count = %h, expected %h", got.size(), row.exp_count);
			errs++;
		end
		for (int i = 0; i < got.size() && i < exp.size(); i++) begin
			r = got[i];
			assert (r == exp[i]) else begin
				$display("** Error: rec_data[%0d] = %h, expected %h", i, r, exp[i]);
				errs++;
			end
		end
		if (row.lat_wr >= 0 && got_cyc.size() > 0) begin
			assert (got_cyc[0] - wr_cyc == row.exp_lat) else begin
				$display("** Error: rec_valid latency = %h, expected %h",
					got_cyc[0] - wr_cyc, row.exp_lat);
				errs++;
			end
		end
		assert (pa_out == row.exp_pa[7:0]) else begin
			$display("** Error: pa_out = %h, expected %h", pa_out, row.exp_pa[7:0]);
			errs++;
		end
		assert (overflow == row.exp_ovf[0]) else begin
			$display("** Error: overflow = %h, expected %h", overflow, row.exp_ovf[0]);
			errs++;
		end

		if (errs == 0) begin
			$display("PASS %s", names[t]);
		end else begin
			$display("FAIL %s with %0d errors", names[t], errs);
			failed_tests++;
		end
		errors += errs;
	endtask

	initial begin
		int total;
		wait (table_ready);
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++)
			total += rows[t].budget;
		#(total * 2 * 10);
		$display("Timeout: the tests did not finish in the expected time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		pllclk        = 1'b0;
		f_reset       = 1'b1;
		reg_wr        = '0;
		pins          = '0;
		pa_in         = '0;
		credit_return = 1'b0;
		lfsr          = 32'h4084;
		cycle         = 0;
		errors        = 0;
		failed_tests  = 0;
		table_ready   = 1'b0;

		build_table();
		table_ready = 1'b1;

		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);

		$display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
			NUM_TESTS - failed_tests, failed_tests, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
